// ==== design/lc3b_pkg.sv ====
`default_nettype none

package lc3b_pkg;

    // **************************************************
    // Basic LC-3b types
    // **************************************************

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_nzp;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // **************************************************
    // Pipeline and hazard structs
    // **************************************************

    // Instruction held in one stage. A br with nzp of zero is a bubble.
    typedef struct packed {
        lc3b_opcode op;
        lc3b_nzp    nzp;
        logic       pred;
        lc3b_word   addr;
    } stage_info_t;

    typedef struct packed {
        logic i_mem_resp;
        logic d_mem_resp;
        logic d_mem_read;
        logic d_mem_write;
        logic inter_read;
        logic inter_write;
    } mem_status_t;

    typedef struct packed {
        logic load;
        logic load_pc;
        logic load_mem_wb_force;
        logic redirect_wb;
        logic flush;
        logic flush_mem_op;
        logic i_mem_read;
    } hazard_ctrl_t;

    // Predictor table geometry and reset value (weakly not taken).
    localparam int         BP_INDEX_BITS  = 5;
    localparam int         BP_ENTRIES     = 1 << BP_INDEX_BITS;
    localparam logic [1:0] BP_RESET_STATE = 2'b01;

    localparam stage_info_t STAGE_NOP = '{op: op_br, nzp: 3'b000, pred: 1'b0, addr: 16'h0000};

endpackage

`default_nettype wire

// ==== design/branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_predictor
    import lc3b_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     i_arst_n,
    input  wire lc3b_word i_if_addr,
    input  wire logic     i_br_instruction,
    input  wire lc3b_word i_wb_addr,
    input  wire logic     i_taken,
    input  wire logic     i_not_taken,
    output logic          o_prediction
);

    logic [1:0]               counters [BP_ENTRIES];
    logic [BP_INDEX_BITS-1:0] if_idx;
    logic [BP_INDEX_BITS-1:0] wb_idx;

    // Word aligned addresses, so bit 0 is skipped.
    assign if_idx = i_if_addr[BP_INDEX_BITS:1];
    assign wb_idx = i_wb_addr[BP_INDEX_BITS:1];

    // Upper counter bit gives the direction.
    assign o_prediction = i_br_instruction & counters[if_idx][1];

    // **************************************************
    // Counter training at WB
    // **************************************************

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < BP_ENTRIES; i++) begin
                counters[i] <= BP_RESET_STATE;
            end
        end else if (i_taken) begin
            if (counters[wb_idx] != 2'b11) begin
                counters[wb_idx] <= counters[wb_idx] + 2'b01;
            end
        end else if (i_not_taken) begin
            if (counters[wb_idx] != 2'b00) begin
                counters[wb_idx] <= counters[wb_idx] - 2'b01;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/stage_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_tracker
    import lc3b_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         i_arst_n,
    input  wire lc3b_word     i_if_instr,
    input  wire lc3b_word     i_if_addr,
    input  wire logic         i_if_pred,
    input  wire hazard_ctrl_t i_ctrl,
    output stage_info_t       o_s_if,
    output stage_info_t       o_s_id,
    output stage_info_t       o_s_ex,
    output stage_info_t       o_s_mem,
    output stage_info_t       o_s_wb,
    output lc3b_opcode        o_op_mem_inter
);

    stage_info_t if_next;
    stage_info_t s_if;
    stage_info_t s_id;
    stage_info_t s_ex;
    stage_info_t s_mem;
    stage_info_t s_wb;
    lc3b_opcode  op_mem_inter;

    // Decode of the fetched word.
    always_comb begin
        if_next.op   = lc3b_opcode'(i_if_instr[15:12]);
        if_next.nzp  = i_if_instr[11:9];
        if_next.pred = i_if_pred;
        if_next.addr = i_if_addr;
    end

    // **************************************************
    // IF/ID register
    // **************************************************

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            s_if <= STAGE_NOP;
        end else if (i_ctrl.load) begin
            s_if <= if_next;
        end
    end

    // **************************************************
    // ID, EX and MEM
    // **************************************************

    // Flush wins over load so a redirect leaves bubbles behind WB.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            s_id  <= STAGE_NOP;
            s_ex  <= STAGE_NOP;
            s_mem <= STAGE_NOP;
        end else if (i_ctrl.flush) begin
            s_id  <= STAGE_NOP;
            s_ex  <= STAGE_NOP;
            s_mem <= STAGE_NOP;
        end else if (i_ctrl.load) begin
            s_id  <= s_if;
            s_ex  <= s_id;
            s_mem <= s_ex;
        end
    end

    // WB drains to a bubble during a stall unless the hazard logic holds it.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            s_wb <= STAGE_NOP;
        end else if (i_ctrl.load) begin
            s_wb <= s_mem;
        end else if (i_ctrl.load_mem_wb_force) begin
            s_wb <= STAGE_NOP;
        end
    end

    // Previous MEM op for the second half of ldi/sti.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            op_mem_inter <= op_br;
        end else begin
            op_mem_inter <= s_mem.op;
        end
    end

    assign o_s_if         = s_if;
    assign o_s_id         = s_id;
    assign o_s_ex         = s_ex;
    assign o_s_mem        = s_mem;
    assign o_s_wb         = s_wb;
    assign o_op_mem_inter = op_mem_inter;

endmodule

`default_nettype wire

// ==== design/hazard_detection.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_detection
    import lc3b_pkg::*;
(
    input  wire stage_info_t i_s_if,
    input  wire stage_info_t i_s_id,
    input  wire stage_info_t i_s_ex,
    input  wire stage_info_t i_s_mem,
    input  wire stage_info_t i_s_wb,
    input  wire lc3b_opcode  i_op_mem_inter,
    input  wire mem_status_t i_mem_status,
    input  wire logic        i_br_enable,
    output hazard_ctrl_t     o_ctrl,
    output logic             o_taken,
    output logic             o_not_taken,
    output logic             o_br_instruction
);

    function automatic logic is_cond_br(input stage_info_t s);
        return (s.op == op_br) && (s.nzp != 3'b000);
    endfunction

    function automatic logic is_ctrl_op(input lc3b_opcode op);
        return (op == op_jmp) || (op == op_jsr) || (op == op_trap);
    endfunction

    function automatic logic is_indirect(input lc3b_opcode op);
        return (op == op_ldi) || (op == op_sti);
    endfunction

    logic         mem_op;
    logic         wb_branch;
    logic         taken;
    logic         not_taken;
    logic         mispredict;
    logic         redirect;
    logic         ctrl_in_flight;
    logic         br_in_flight;
    logic         fetch_on;
    hazard_ctrl_t ctrl;

    assign mem_op    = i_mem_status.d_mem_read | i_mem_status.d_mem_write;
    assign wb_branch = is_cond_br(i_s_wb);

    // **************************************************
    // Branch resolution and redirect at WB
    // **************************************************

    assign taken      = wb_branch & i_br_enable;
    assign not_taken  = wb_branch & ~i_br_enable;
    assign mispredict = (taken & ~i_s_wb.pred) | (not_taken & i_s_wb.pred);
    assign redirect   = mispredict | is_ctrl_op(i_s_wb.op);

    assign ctrl_in_flight = is_ctrl_op(i_s_id.op) | is_ctrl_op(i_s_ex.op)
                          | is_ctrl_op(i_s_mem.op);
    assign br_in_flight   = is_cond_br(i_s_id) | is_cond_br(i_s_ex) | is_cond_br(i_s_mem);

    // No fetch while a jump target is still unknown.
    assign fetch_on = ~ctrl_in_flight & ~redirect;

    // **************************************************
    // Load, PC load and flush
    // **************************************************

    always_comb begin
        ctrl                   = '0;
        ctrl.load_mem_wb_force = 1'b1;
        ctrl.redirect_wb       = redirect;
        ctrl.i_mem_read        = fetch_on;

        // Base table on {i_mem_resp, d_mem_resp, mem_op}.
        case ({i_mem_status.i_mem_resp, i_mem_status.d_mem_resp, mem_op})
            3'b000:  {ctrl.load, ctrl.load_pc} = 2'b10;
            3'b001:  {ctrl.load, ctrl.load_pc} = 2'b00;
            3'b010:  {ctrl.load, ctrl.load_pc} = 2'b11;
            3'b011:  {ctrl.load, ctrl.load_pc} = 2'b10;
            3'b100:  {ctrl.load, ctrl.load_pc} = 2'b11;
            3'b101:  {ctrl.load, ctrl.load_pc} = 2'b00;
            default: {ctrl.load, ctrl.load_pc} = 2'b11;
        endcase

        // First half of ldi/sti always takes an extra cycle.
        if (is_indirect(i_s_mem.op)) begin
            ctrl.load    = 1'b0;
            ctrl.load_pc = 1'b0;
        end

        // Second half done once its data response is back.
        if (is_indirect(i_op_mem_inter) && !i_mem_status.inter_read
                && !i_mem_status.inter_write && i_mem_status.d_mem_resp) begin
            ctrl.load    = 1'b1;
            ctrl.load_pc = i_mem_status.i_mem_resp;
        end

        if (mispredict) begin
            ctrl.load_pc      = 1'b1;
            ctrl.flush        = 1'b1;
            ctrl.flush_mem_op = 1'b1;
        end

        if (is_ctrl_op(i_s_wb.op)) begin
            ctrl.load_pc = 1'b1;
        end

        if (!fetch_on && !redirect) begin
            ctrl.load_pc = 1'b0;
        end

        // An outstanding fetch behind a branch freezes the whole pipe.
        if (!i_mem_status.i_mem_resp && fetch_on && br_in_flight && !wb_branch) begin
            ctrl.load              = 1'b0;
            ctrl.load_pc           = 1'b0;
            ctrl.load_mem_wb_force = 1'b0;
        end
    end

    assign o_ctrl           = ctrl;
    assign o_taken          = taken;
    assign o_not_taken      = not_taken;
    assign o_br_instruction = is_cond_br(i_s_if);

endmodule

`default_nettype wire

// ==== design/hazard_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit_top
    import lc3b_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        i_arst_n,
    input  wire lc3b_word    i_if_instr,
    input  wire lc3b_word    i_if_addr,
    input  wire mem_status_t i_mem_status,
    input  wire logic        i_br_enable,
    output hazard_ctrl_t     o_ctrl,
    output logic             o_prediction,
    output logic             o_taken,
    output logic             o_not_taken
);

    stage_info_t s_if;
    stage_info_t s_id;
    stage_info_t s_ex;
    stage_info_t s_mem;
    stage_info_t s_wb;
    lc3b_opcode  op_mem_inter;
    logic        br_instruction;

    stage_tracker u_stage_tracker (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_if_instr     (i_if_instr),
        .i_if_addr      (i_if_addr),
        .i_if_pred      (o_prediction),
        .i_ctrl         (o_ctrl),
        .o_s_if         (s_if),
        .o_s_id         (s_id),
        .o_s_ex         (s_ex),
        .o_s_mem        (s_mem),
        .o_s_wb         (s_wb),
        .o_op_mem_inter (op_mem_inter)
    );

    hazard_detection u_hazard_detection (
        .i_s_if           (s_if),
        .i_s_id           (s_id),
        .i_s_ex           (s_ex),
        .i_s_mem          (s_mem),
        .i_s_wb           (s_wb),
        .i_op_mem_inter   (op_mem_inter),
        .i_mem_status     (i_mem_status),
        .i_br_enable      (i_br_enable),
        .o_ctrl           (o_ctrl),
        .o_taken          (o_taken),
        .o_not_taken      (o_not_taken),
        .o_br_instruction (br_instruction)
    );

    branch_predictor u_branch_predictor (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_if_addr        (i_if_addr),
        .i_br_instruction (br_instruction),
        .i_wb_addr        (s_wb.addr),
        .i_taken          (o_taken),
        .i_not_taken      (o_not_taken),
        .o_prediction     (o_prediction)
    );

endmodule

`default_nettype wire

// ==== verif/hazard_ref_model.svh ====
`ifndef HAZARD_REF_MODEL_SVH
`define HAZARD_REF_MODEL_SVH

// Expected DUT outputs for one cycle.
typedef struct packed {
    hazard_ctrl_t ctrl;
    logic         pred;
    logic         taken;
    logic         not_taken;
} expect_t;

// Stage model with index 0 at IF and index 4 at WB.
stage_info_t ref_st [5];
lc3b_opcode  ref_inter;
logic [1:0]  ref_cnt [BP_ENTRIES];

function automatic logic cond_branch(input stage_info_t s);
    return s.op == op_br && s.nzp != 3'b000;
endfunction

function automatic logic jump_op(input lc3b_opcode op);
    return op inside {op_jmp, op_jsr, op_trap};
endfunction

function automatic logic two_access_op(input lc3b_opcode op);
    return op inside {op_ldi, op_sti};
endfunction

function automatic expect_t expected_outputs(input lc3b_word if_addr, input mem_status_t ms,
                                             input logic br_en);
    expect_t e;
    logic    mem_busy;
    logic    data_only;
    logic    miss;
    logic    jump_ahead;
    logic    br_ahead;
    e           = '0;
    mem_busy    = (ms.d_mem_read || ms.d_mem_write) && !ms.d_mem_resp;
    data_only   = ms.d_mem_resp && !ms.d_mem_read && !ms.d_mem_write;
    e.taken     = cond_branch(ref_st[4]) && br_en;
    e.not_taken = cond_branch(ref_st[4]) && !br_en;
    miss        = (e.taken || e.not_taken) && (br_en != ref_st[4].pred);
    jump_ahead  = jump_op(ref_st[1].op) || jump_op(ref_st[2].op) || jump_op(ref_st[3].op);
    br_ahead    = cond_branch(ref_st[1]) || cond_branch(ref_st[2]) || cond_branch(ref_st[3]);
    e.pred      = cond_branch(ref_st[0]) && ref_cnt[if_addr[BP_INDEX_BITS:1]][1];

    e.ctrl.redirect_wb       = miss || jump_op(ref_st[4].op);
    e.ctrl.i_mem_read        = !jump_ahead && !e.ctrl.redirect_wb;
    e.ctrl.load_mem_wb_force = 1'b1;

    // Pending data access without its response stops the pipe.
    e.ctrl.load    = !mem_busy;
    e.ctrl.load_pc = !mem_busy && (ms.i_mem_resp || data_only);

    if (two_access_op(ref_st[3].op)) begin
        e.ctrl.load    = 1'b0;
        e.ctrl.load_pc = 1'b0;
    end
    if (two_access_op(ref_inter) && !ms.inter_read && !ms.inter_write && ms.d_mem_resp) begin
        e.ctrl.load    = 1'b1;
        e.ctrl.load_pc = ms.i_mem_resp;
    end
    if (miss) begin
        e.ctrl.flush        = 1'b1;
        e.ctrl.flush_mem_op = 1'b1;
    end
    if (e.ctrl.redirect_wb) begin
        e.ctrl.load_pc = 1'b1;
    end else if (jump_ahead) begin
        e.ctrl.load_pc = 1'b0;
    end

    // Fetch still outstanding behind a branch freezes every stage.
    if (!ms.i_mem_resp && e.ctrl.i_mem_read && br_ahead && !cond_branch(ref_st[4])) begin
        e.ctrl.load              = 1'b0;
        e.ctrl.load_pc           = 1'b0;
        e.ctrl.load_mem_wb_force = 1'b0;
    end
    return e;
endfunction

task automatic advance_model(input lc3b_word instr, input lc3b_word addr, input expect_t e);
    logic [BP_INDEX_BITS-1:0] wb_idx;
    wb_idx = ref_st[4].addr[BP_INDEX_BITS:1];
    if (e.taken && ref_cnt[wb_idx] != 2'b11) begin
        ref_cnt[wb_idx] = ref_cnt[wb_idx] + 2'b01;
    end else if (e.not_taken && ref_cnt[wb_idx] != 2'b00) begin
        ref_cnt[wb_idx] = ref_cnt[wb_idx] - 2'b01;
    end
    ref_inter = ref_st[3].op;
    if (e.ctrl.load) begin
        ref_st[4] = ref_st[3];
    end else if (e.ctrl.load_mem_wb_force) begin
        ref_st[4] = STAGE_NOP;
    end
    for (int i = 3; i >= 1; i--) begin
        if (e.ctrl.flush) begin
            ref_st[i] = STAGE_NOP;
        end else if (e.ctrl.load) begin
            ref_st[i] = ref_st[i-1];
        end
    end
    if (e.ctrl.load) begin
        ref_st[0] = '{op: lc3b_opcode'(instr[15:12]), nzp: instr[11:9],
                      pred: e.pred, addr: addr};
    end
endtask

task automatic reset_model();
    for (int i = 0; i < 5; i++) begin
        ref_st[i] = STAGE_NOP;
    end
    for (int i = 0; i < BP_ENTRIES; i++) begin
        ref_cnt[i] = BP_RESET_STATE;
    end
    ref_inter = op_br;
endtask

`endif

// ==== verif/tb_hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hazard_unit
    import lc3b_pkg::*;
();

    localparam int       RESET_CYCLES    = 5;
    localparam int       PHASE_LIMIT     = 50;
    localparam int       RANDOM_CYCLES   = 2000;
    // Stimulus length with half again as margin.
    localparam int       WATCHDOG_CYCLES = RANDOM_CYCLES * 3 / 2;
    localparam lc3b_word TRAIN_ADDR      = 16'h3024;

    `include "hazard_ref_model.svh"

    logic         clk;
    logic         i_arst_n;
    lc3b_word     i_if_instr;
    lc3b_word     i_if_addr;
    mem_status_t  i_mem_status;
    logic         i_br_enable;
    hazard_ctrl_t o_ctrl;
    logic         o_prediction;
    logic         o_taken;
    logic         o_not_taken;
    int           seed;
    int           phase;
    logic [4:1]   seen;
    logic         load_seen;
    expect_t      exp_now;

    hazard_unit_top uut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic check_field(input string name, input logic expected, input logic actual);
        assert (actual === expected)
        else begin
            $display("Error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic wait_for_seen(input logic [4:1] mask, input string what);
        int cycles;
        cycles = 0;
        while ((seen & mask) == '0) begin
            @(posedge clk);
            cycles++;
            if (cycles > PHASE_LIMIT) begin
                $display("Gave up waiting for %s after %0d cycles", what, PHASE_LIMIT);
                $display("TEST FAILED");
                $fatal(1, "Phase timeout");
            end
        end
    endtask

    // Mostly branches, with indirect loads, stores and jumps mixed in.
    function automatic lc3b_word random_instr();
        lc3b_word w;
        int       pick;
        w    = lc3b_word'($random(seed));
        pick = int'($unsigned($random(seed)) % 16);
        case (pick)
            0, 1, 2, 3, 4, 5: w[15:12] = op_br;
            6:       w[15:12] = op_ldi;
            7:       w[15:12] = op_sti;
            8:       w[15:12] = op_jmp;
            9:       w[15:12] = op_jsr;
            10:      w[15:12] = op_trap;
            default: ;
        endcase
        return w;
    endfunction

    function automatic mem_status_t random_status();
        mem_status_t s;
        logic [31:0] r;
        r             = $random(seed);
        s.i_mem_resp  = r[1:0] != 2'b00;
        s.d_mem_resp  = r[2];
        s.d_mem_read  = r[4:3] == 2'b00;
        s.d_mem_write = r[7:5] == 3'b000;
        s.inter_read  = r[10:8] == 3'b000;
        s.inter_write = r[13:11] == 3'b000;
        return s;
    endfunction

    // **************************************************
    // Stimulus
    // **************************************************

    initial begin
        logic [31:0] r;
        seed          = 32'h13f4;
        phase         = 0;
        i_arst_n     <= 1'b0;
        i_if_instr   <= '0;
        i_if_addr    <= '0;
        i_mem_status <= '0;
        i_br_enable  <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        i_arst_n <= 1'b1;
        repeat (3) @(posedge clk);

        // Branch stream at one address that resolves taken and then not taken.
        i_if_instr   <= 16'h0e00;
        i_if_addr    <= TRAIN_ADDR;
        i_mem_status <= mem_status_t'(6'b100000);
        i_br_enable  <= 1'b1;
        phase         = 1;
        wait_for_seen(4'b0001, "a taken prediction");
        i_br_enable <= 1'b0;
        phase        = 2;
        wait_for_seen(4'b0010, "the prediction to fall back to not taken");

        phase = 3;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            @(posedge clk);
            // A new word is fetched only after the current one was taken in.
            if (load_seen) begin
                i_if_instr <= random_instr();
                r           = $random(seed);
                i_if_addr  <= {10'h0c0, r[2:0], 3'b000};
            end
            i_mem_status <= random_status();
            r             = $random(seed);
            i_br_enable  <= r[0];
        end
        @(posedge clk);
        if (seen == 4'b1111) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("Random stimulus never produced both a flush and a full freeze");
            $display("TEST FAILED");
            $fatal(1, "Missing scenario");
        end
    end

    // **************************************************
    // Compare against the reference model
    // **************************************************

    always @(negedge clk) begin
        if (i_arst_n !== 1'b1) begin
            reset_model();
            seen = '0;
        end else begin
            exp_now = expected_outputs(i_if_addr, i_mem_status, i_br_enable);
            check_field("o_ctrl.load", exp_now.ctrl.load, o_ctrl.load);
            check_field("o_ctrl.load_pc", exp_now.ctrl.load_pc, o_ctrl.load_pc);
            check_field("o_ctrl.load_mem_wb_force", exp_now.ctrl.load_mem_wb_force,
                        o_ctrl.load_mem_wb_force);
            check_field("o_ctrl.redirect_wb", exp_now.ctrl.redirect_wb, o_ctrl.redirect_wb);
            check_field("o_ctrl.flush", exp_now.ctrl.flush, o_ctrl.flush);
            check_field("o_ctrl.flush_mem_op", exp_now.ctrl.flush_mem_op, o_ctrl.flush_mem_op);
            check_field("o_ctrl.i_mem_read", exp_now.ctrl.i_mem_read, o_ctrl.i_mem_read);
            check_field("o_prediction", exp_now.pred, o_prediction);
            check_field("o_taken", exp_now.taken, o_taken);
            check_field("o_not_taken", exp_now.not_taken, o_not_taken);
            if (phase == 1 && o_prediction) begin
                seen[1] = 1'b1;
            end
            if (phase == 2 && cond_branch(ref_st[0]) && !o_prediction) begin
                seen[2] = 1'b1;
            end
            if (phase == 3 && o_ctrl.flush) begin
                seen[3] = 1'b1;
            end
            if (phase == 3 && !o_ctrl.load_mem_wb_force) begin
                seen[4] = 1'b1;
            end
            load_seen = o_ctrl.load;
            advance_model(i_if_instr, i_if_addr, exp_now);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the stimulus ended", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verif
design/lc3b_pkg.sv
design/branch_predictor.sv
design/stage_tracker.sv
design/hazard_detection.sv
design/hazard_unit_top.sv
verif/tb_hazard_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator and run. The exit status follows the simulation result.
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps --top-module tb_hazard_unit -f flist.f &&
./obj_dir/Vtb_hazard_unit ||
{ echo "Simulation failed"; exit 1; }
